// ==== mipsExec.f ====
src/mipsIsaPkg.sv
src/mipsExecPkg.sv
src/mipsDecode.sv
src/mipsExecute.sv
src/mipsResult.sv
src/mipsExec.sv
verif/mipsChecker.sv
verif/tbMipsExec.sv

// ==== build.sh ====
#!/bin/sh
# Compile and run the mipsExec testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tbMipsExec -f mipsExec.f -o simMipsExec
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simMipsExec > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -qF '*** FAILED ***' "$log"; then
	exit 1
fi
if ! grep -qF '*** PASSED ***' "$log"; then
	echo "Simulation log holds no final result"
	exit 1
fi
exit 0

// ==== verif/tbMipsExec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMipsExec import mipsIsaPkg::*, mipsExecPkg::*; ();

	localparam int itemsPerTest = 200;
	localparam int numTests = 6;
	localparam int cycleLimit = numTests * itemsPerTest * 4 + 200; // Stalls average 2 cycles

	localparam logic [5:0] rFuncs [16] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT,
		FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SLT, FN_SRAV};
	localparam logic [5:0] iOps [8] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
		OP_LUI, OP_SLTI};
	localparam logic [5:0] hlFuncs [8] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MFHI, FN_MFLO,
		FN_MTHI, FN_MTLO};
	localparam logic [5:0] memOps [10] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
		OP_SB, OP_SH, OP_SW};
	localparam logic [5:0] badOps [4] = '{6'h01, 6'h02, 6'h08, 6'h3f}; // REGIMM, J, ADDI
	localparam logic [5:0] badFuncs [4] = '{6'h08, 6'h0c, 6'h20, 6'h3f}; // JR, SYSCALL, ADD

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	instrU instr;
	logic [31:0] readData1;
	logic [31:0] readData2;
	logic outValid;
	logic outReady;
	resultS out;
	int errorCount;
	int inCount;
	int outCount;
	int pendingCount;
	int tbErrors;
	int cycles = 0;
	logic [31:0] rngState;

	mipsExec dut (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.instr(instr),
		.readData1(readData1),
		.readData2(readData2),
		.inReady(inReady),
		.outValid(outValid),
		.out(out),
		.outReady(outReady)
	);

	mipsChecker uChecker (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.instr(instr),
		.readData1(readData1),
		.readData2(readData2),
		.outValid(outValid),
		.outReady(outReady),
		.out(out),
		.errorCount(errorCount),
		.inCount(inCount),
		.outCount(outCount),
		.pendingCount(pendingCount)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Timeout: the run is still busy after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic makeItem(input int kind, input int idx, output logic [31:0] w,
			output logic [31:0] a, output logic [31:0] b);
		logic [31:0] r;
		logic [31:0] ea;
		logic [1:0] off;
		r = nextRand();
		a = nextRand();
		b = nextRand();
		case (kind)
			0: w = {6'h00, r[25:6], rFuncs[r[31:28]]};
			1: w = {iOps[r[31:29]], r[25:0]};
			2: begin
				w = {6'h00, r[25:6], hlFuncs[r[31:29]]};
				if (r[28:26] == 3'd0) begin
					b = 32'h0;
				end else if (r[28:26] == 3'd1) begin
					a = 32'h8000_0000; // Signed overflow case
					b = 32'hffff_ffff;
				end
			end
			3: begin
				w = {memOps[4'(idx % 10)], r[25:0]};
				off = 2'(idx / 10); // Every kind at every offset
				ea = a + {{16{w[15]}}, w[15:0]};
				a = a + {30'h0, off - ea[1:0]};
			end
			default: begin
				case (idx % 4)
					0: w = {6'h00, r[25:6], (r[31] ? FN_MTHI : FN_MTLO)};
					1: w = {badOps[r[31:30]], r[25:0]};
					2: w = {6'h00, r[25:6], badFuncs[r[31:30]]};
					default: w = {6'h00, r[25:6], (r[31] ? FN_MFHI : FN_MFLO)};
				endcase
			end
		endcase
	endtask

	task automatic sendInstr(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
			input logic stall);
		logic [31:0] r;
		@(negedge clk);
		r = nextRand();
		inValid = 1'b1;
		instr = w;
		readData1 = a;
		readData2 = b;
		outReady = stall ? r[0] : 1'b1;
		#1;
		while (!inReady) begin // Payload held until taken
			@(negedge clk);
			r = nextRand();
			outReady = stall ? r[0] : 1'b1;
			#1;
		end
		@(posedge clk);
	endtask

	task automatic runTest(input string name, input int kind, input logic stall);
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		int errBefore;
		int k;
		errBefore = errorCount;
		for (int i = 0; i < itemsPerTest; i++) begin
			k = (kind == 5) ? int'(nextRand() % 32'd5) : kind;
			makeItem(k, i, w, a, b);
			sendInstr(w, a, b, stall);
		end
		@(negedge clk);
		inValid = 1'b0;
		outReady = 1'b1;
		while (pendingCount != 0) begin
			@(negedge clk);
		end
		$display("test %s: %0d items, %0d errors", name, itemsPerTest, errorCount - errBefore);
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		instr = '0;
		readData1 = 32'h0;
		readData2 = 32'h0;
		outReady = 1'b1;
		tbErrors = 0;
		rngState = 32'hb32c37fb;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		#1;
		if (!inReady || outValid) begin
			$display("DUT not idle after reset: inReady %b, outValid %b", inReady, outValid);
			tbErrors++;
		end
		runTest("register ALU and shifts", 0, 1'b0);
		runTest("immediates", 1, 1'b0);
		runTest("HI/LO", 2, 1'b1);
		runTest("memory addressing", 3, 1'b0);
		runTest("illegal codes", 4, 1'b0);
		runTest("back-pressure", 5, 1'b1);
		if (inCount != outCount) begin
			$display("Results lost or duplicated: %0d inputs but %0d outputs", inCount, outCount);
			tbErrors++;
		end
		$display("tests %0d, inputs %0d, outputs %0d, errors %0d", numTests, inCount, outCount,
			errorCount + tbErrors);
		if (errorCount + tbErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/mipsChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsChecker import mipsIsaPkg::*, mipsExecPkg::*; (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic inReady,
	input instrU instr,
	input logic [31:0] readData1,
	input logic [31:0] readData2,
	input logic outValid,
	input logic outReady,
	input resultS out,
	output int errorCount,
	output int inCount,
	output int outCount,
	output int pendingCount
);

	resultS expQ[$]; // Expected results in program order
	resultS expected;
	logic [31:0] hiM;
	logic [31:0] loM;

	function automatic resultS refModel(input logic [31:0] word, input logic [31:0] a,
			input logic [31:0] b);
		resultS r;
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] sh;
		logic [31:0] se;
		logic [31:0] ze;
		logic [31:0] ea;
		logic [1:0] off;
		r = '0;
		op = word[31:26];
		fn = word[5:0];
		sh = word[10:6];
		se = {{16{word[15]}}, word[15:0]};
		ze = {16'h0, word[15:0]};
		ea = a + se;
		off = ea[1:0];
		if (op == OP_SPECIAL) begin
			case (fn)
				FN_ADDU: r.value = a + b;
				FN_SUBU: r.value = a - b;
				FN_AND: r.value = a & b;
				FN_OR: r.value = a | b;
				FN_XOR: r.value = a ^ b;
				FN_SLT: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FN_SLTU: r.value = (a < b) ? 32'd1 : 32'd0;
				FN_SLL: r.value = b << sh;
				FN_SRL: r.value = b >> sh;
				FN_SRA: r.value = $signed(b) >>> sh;
				FN_SLLV: r.value = b << a[4:0];
				FN_SRLV: r.value = b >> a[4:0];
				FN_SRAV: r.value = $signed(b) >>> a[4:0];
				FN_MFHI: r.value = hiM;
				FN_MFLO: r.value = loM;
				FN_MTHI: hiM = a;
				FN_MTLO: loM = a;
				FN_MULT: {hiM, loM} = {{32{a[31]}}, a} * {{32{b[31]}}, b};
				FN_MULTU: {hiM, loM} = {32'h0, a} * {32'h0, b};
				FN_DIV: begin
					if (b == 32'h0) begin
						loM = 32'hffff_ffff;
						hiM = a;
					end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
						loM = a; // Quotient overflows
						hiM = 32'h0;
					end else begin
						loM = $signed(a) / $signed(b);
						hiM = $signed(a) % $signed(b);
					end
				end
				FN_DIVU: begin
					if (b == 32'h0) begin
						loM = 32'hffff_ffff;
						hiM = a;
					end else begin
						loM = a / b;
						hiM = a % b;
					end
				end
				default: r.illegal = 1'b1;
			endcase
		end else begin
			case (op)
				OP_ADDIU: r.value = a + se;
				OP_SLTI: r.value = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
				OP_SLTIU: r.value = (a < se) ? 32'd1 : 32'd0;
				OP_ANDI: r.value = a & ze;
				OP_ORI: r.value = a | ze;
				OP_XORI: r.value = a ^ ze;
				OP_LUI: r.value = {word[15:0], 16'h0};
				OP_LB, OP_LBU, OP_SB: begin
					r.byteEnable = {off == 2'd3, off == 2'd2, off == 2'd1, off == 2'd0};
				end
				OP_LH, OP_LHU, OP_SH: begin
					r.addrError = off[0];
					r.byteEnable = (off == 2'd0) ? 4'b0011 : (off == 2'd2) ? 4'b1100 : 4'b0000;
				end
				OP_LW, OP_SW: begin
					r.addrError = off != 2'd0;
					r.byteEnable = r.addrError ? 4'b0000 : 4'b1111;
				end
				OP_LWL: r.byteEnable = {1'b1, off <= 2'd2, off <= 2'd1, off == 2'd0};
				OP_LWR: r.byteEnable = {off == 2'd3, off >= 2'd2, off >= 2'd1, 1'b1};
				default: r.illegal = 1'b1;
			endcase
			if (op[5] && !r.illegal) begin
				r.value = {ea[31:2], 2'b00}; // Aligned address
			end
		end
		return r;
	endfunction

	task automatic compareField(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("[FAIL] time %0t ns: %s is %h, expected %h", $time, name, got, want);
			errorCount++;
		end
	endtask

	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			expQ.delete();
			hiM = 32'h0;
			loM = 32'h0;
			errorCount = 0;
			inCount = 0;
			outCount = 0;
		end else begin
			// Input stalls only while all three stages hold an item
			compareField("inReady", {31'h0, inReady},
				{31'h0, !(expQ.size() == 3 && !outReady)});
			if (outValid && outReady) begin // Pop before push
				outCount++;
				if (expQ.size() == 0) begin
					$display("Time %0t ns: a result came out with no input left to match it",
						$time);
					errorCount++;
				end else begin
					expected = expQ.pop_front();
					compareField("out.value", out.value, expected.value);
					compareField("out.byteEnable", {28'h0, out.byteEnable},
						{28'h0, expected.byteEnable});
					compareField("out.addrError", {31'h0, out.addrError},
						{31'h0, expected.addrError});
					compareField("out.illegal", {31'h0, out.illegal}, {31'h0, expected.illegal});
				end
			end
			if (inValid && inReady) begin
				inCount++;
				expQ.push_back(refModel(instr, readData1, readData2));
			end
		end
		pendingCount = expQ.size();
	end

endmodule

`default_nettype wire

// ==== src/mipsExec.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsExec import mipsIsaPkg::*, mipsExecPkg::*; (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input instrU instr,
	input logic [31:0] readData1,
	input logic [31:0] readData2,
	output logic inReady,
	output logic outValid,
	output resultS out,
	input logic outReady
);

	logic decValid;
	logic decReady;
	decodedS dec;
	logic exValid;
	logic exReady;
	execS ex;

	mipsDecode uDecode (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.instr(instr),
		.readData1(readData1),
		.readData2(readData2),
		.inReady(inReady),
		.decValid(decValid),
		.dec(dec),
		.decReady(decReady)
	);

	mipsExecute uExecute (
		.clk(clk),
		.rstN(rstN),
		.decValid(decValid),
		.dec(dec),
		.decReady(decReady),
		.exValid(exValid),
		.ex(ex),
		.exReady(exReady)
	);

	mipsResult uResult (
		.clk(clk),
		.rstN(rstN),
		.exValid(exValid),
		.ex(ex),
		.exReady(exReady),
		.outValid(outValid),
		.out(out),
		.outReady(outReady)
	);

endmodule

`default_nettype wire

// ==== src/mipsResult.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsResult import mipsExecPkg::*; (
	input logic clk,
	input logic rstN,
	input logic exValid,
	input execS ex,
	output logic exReady,
	output logic outValid,
	output resultS out,
	input logic outReady
);

	logic [1:0] offset;
	logic [3:0] mask;
	logic misaligned;
	resultS outNext;

	assign exReady = !outValid || outReady;
	assign offset = ex.value[1:0]; // Byte within the word

	always_comb begin
		case (ex.memKind)
			MEM_BYTE: mask = 4'b0001 << offset;
			MEM_HALF: mask = 4'b0011 << offset;
			MEM_WORD: mask = 4'b1111;
			MEM_LEFT: mask = 4'b1111 << offset; // Offset up to byte 3
			MEM_RIGHT: mask = 4'b1111 >> (2'd3 - offset); // Byte 0 up to offset
			default: mask = 4'b0000;
		endcase
	end

	assign misaligned = (ex.memKind == MEM_HALF && offset[0])
		|| (ex.memKind == MEM_WORD && offset != 2'd0);

	always_comb begin
		outNext.value = (ex.memKind == MEM_NONE) ? ex.value : {ex.value[31:2], 2'b00};
		outNext.byteEnable = misaligned ? 4'b0000 : mask;
		outNext.addrError = misaligned;
		outNext.illegal = ex.illegal;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (exReady) begin
			outValid <= exValid;
		end
	end

	always_ff @(posedge clk) begin
		if (exValid && exReady) begin
			out <= outNext;
		end
	end

endmodule

`default_nettype wire

// ==== src/mipsExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsExecute import mipsExecPkg::*; (
	input logic clk,
	input logic rstN,
	input logic decValid,
	input decodedS dec,
	output logic decReady,
	output logic exValid,
	output execS ex,
	input logic exReady
);

	logic [31:0] hi;
	logic [31:0] lo;
	logic take;
	logic [63:0] prodS;
	logic [63:0] prodU;
	logic divByZero;
	logic divOverflow;
	logic [31:0] divisorS;
	logic [31:0] divisorU;
	logic signed [31:0] quotS;
	logic signed [31:0] remS;
	logic [31:0] quotU;
	logic [31:0] remU;
	execS exNext;

	assign decReady = !exValid || exReady;
	assign take = decValid && decReady;

	assign prodS = 64'($signed(dec.opA)) * 64'($signed(dec.opB)); // Operands sign-extend to 64 bits
	assign prodU = {32'h0, dec.opA} * {32'h0, dec.opB};

	assign divByZero = dec.opB == 32'h0;
	assign divOverflow = dec.opA == 32'h8000_0000 && dec.opB == 32'hffff_ffff;
	// Dividing by one gives opA and 0 for the overflow case
	assign divisorS = (divByZero || divOverflow) ? 32'd1 : dec.opB;
	assign divisorU = divByZero ? 32'd1 : dec.opB;
	assign quotS = $signed(dec.opA) / $signed(divisorS);
	assign remS = $signed(dec.opA) % $signed(divisorS);
	assign quotU = dec.opA / divisorU;
	assign remU = dec.opA % divisorU;

	always_comb begin
		exNext.value = 32'h0; // HI/LO writers and NOP
		exNext.memKind = dec.memKind;
		exNext.illegal = dec.illegal;
		case (dec.aluOp)
			ALU_ADD: exNext.value = dec.opA + dec.opB;
			ALU_SUB: exNext.value = dec.opA - dec.opB;
			ALU_AND: exNext.value = dec.opA & dec.opB;
			ALU_OR: exNext.value = dec.opA | dec.opB;
			ALU_XOR: exNext.value = dec.opA ^ dec.opB;
			ALU_SLT: exNext.value = {31'h0, $signed(dec.opA) < $signed(dec.opB)};
			ALU_SLTU: exNext.value = {31'h0, dec.opA < dec.opB};
			ALU_SLL: exNext.value = dec.opB << dec.shamt;
			ALU_SRL: exNext.value = dec.opB >> dec.shamt;
			ALU_SRA: exNext.value = $signed(dec.opB) >>> dec.shamt;
			ALU_LUI: exNext.value = {dec.opB[15:0], 16'h0};
			ALU_MFHI: exNext.value = hi;
			ALU_MFLO: exNext.value = lo;
			default: exNext.value = 32'h0;
		endcase
	end

	// HI/LO change as the instruction enters the execute register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hi <= 32'h0;
			lo <= 32'h0;
		end else if (take) begin
			case (dec.aluOp)
				ALU_MTHI: hi <= dec.opA;
				ALU_MTLO: lo <= dec.opA;
				ALU_MULT: {hi, lo} <= prodS;
				ALU_MULTU: {hi, lo} <= prodU;
				ALU_DIV: begin
					lo <= divByZero ? 32'hffff_ffff : quotS;
					hi <= divByZero ? dec.opA : remS;
				end
				ALU_DIVU: begin
					lo <= divByZero ? 32'hffff_ffff : quotU;
					hi <= divByZero ? dec.opA : remU;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid <= 1'b0;
		end else if (decReady) begin
			exValid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			ex <= exNext;
		end
	end

endmodule

`default_nettype wire

// ==== src/mipsDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsDecode import mipsIsaPkg::*, mipsExecPkg::*; (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input instrU instr,
	input logic [31:0] readData1,
	input logic [31:0] readData2,
	output logic inReady,
	output logic decValid,
	output decodedS dec,
	input logic decReady
);

	logic [31:0] immSE;
	logic [31:0] immZE;
	decodedS decNext;

	assign immSE = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign immZE = {16'h0, instr.i.imm};
	assign inReady = !decValid || decReady; // Empty or draining this cycle

	always_comb begin
		decNext.aluOp = ALU_NOP;
		decNext.memKind = MEM_NONE;
		decNext.opA = readData1;
		decNext.opB = readData2;
		decNext.shamt = instr.r.func[2] ? readData1[4:0] : instr.r.shamt; // SLLV/SRLV/SRAV
		decNext.illegal = 1'b0;
		if (instr.r.opcode == OP_SPECIAL) begin
			case (instr.r.func)
				FN_SLL, FN_SLLV: decNext.aluOp = ALU_SLL;
				FN_SRL, FN_SRLV: decNext.aluOp = ALU_SRL;
				FN_SRA, FN_SRAV: decNext.aluOp = ALU_SRA;
				FN_MFHI: decNext.aluOp = ALU_MFHI;
				FN_MTHI: decNext.aluOp = ALU_MTHI;
				FN_MFLO: decNext.aluOp = ALU_MFLO;
				FN_MTLO: decNext.aluOp = ALU_MTLO;
				FN_MULT: decNext.aluOp = ALU_MULT;
				FN_MULTU: decNext.aluOp = ALU_MULTU;
				FN_DIV: decNext.aluOp = ALU_DIV;
				FN_DIVU: decNext.aluOp = ALU_DIVU;
				FN_ADDU: decNext.aluOp = ALU_ADD;
				FN_SUBU: decNext.aluOp = ALU_SUB;
				FN_AND: decNext.aluOp = ALU_AND;
				FN_OR: decNext.aluOp = ALU_OR;
				FN_XOR: decNext.aluOp = ALU_XOR;
				FN_SLT: decNext.aluOp = ALU_SLT;
				FN_SLTU: decNext.aluOp = ALU_SLTU;
				default: decNext.illegal = 1'b1;
			endcase
		end else begin
			decNext.opB = immSE; // Most I-format ops sign-extend
			case (instr.i.opcode)
				OP_ADDIU: decNext.aluOp = ALU_ADD;
				OP_SLTI: decNext.aluOp = ALU_SLT;
				OP_SLTIU: decNext.aluOp = ALU_SLTU;
				OP_ANDI: begin
					decNext.aluOp = ALU_AND;
					decNext.opB = immZE;
				end
				OP_ORI: begin
					decNext.aluOp = ALU_OR;
					decNext.opB = immZE;
				end
				OP_XORI: begin
					decNext.aluOp = ALU_XOR;
					decNext.opB = immZE;
				end
				OP_LUI: begin
					decNext.aluOp = ALU_LUI;
					decNext.opB = immZE;
				end
				OP_LB, OP_LBU, OP_SB: begin
					decNext.aluOp = ALU_ADD;
					decNext.memKind = MEM_BYTE;
				end
				OP_LH, OP_LHU, OP_SH: begin
					decNext.aluOp = ALU_ADD;
					decNext.memKind = MEM_HALF;
				end
				OP_LW, OP_SW: begin
					decNext.aluOp = ALU_ADD;
					decNext.memKind = MEM_WORD;
				end
				OP_LWL: begin
					decNext.aluOp = ALU_ADD;
					decNext.memKind = MEM_LEFT;
				end
				OP_LWR: begin
					decNext.aluOp = ALU_ADD;
					decNext.memKind = MEM_RIGHT;
				end
				default: decNext.illegal = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decValid <= 1'b0;
		end else if (inReady) begin
			decValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			dec <= decNext;
		end
	end

endmodule

`default_nettype wire

// ==== src/mipsExecPkg.sv ====
`default_nettype none

package mipsExecPkg;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_LUI,
		ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
		ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
		ALU_NOP
	} aluOpE;

	typedef enum logic [2:0] {
		MEM_NONE,
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD,
		MEM_LEFT, // LWL
		MEM_RIGHT // LWR
	} memKindE;

	typedef struct packed {
		aluOpE aluOp;
		memKindE memKind;
		logic [31:0] opA;
		logic [31:0] opB; // readData2 or extended immediate
		logic [4:0] shamt;
		logic illegal;
	} decodedS;

	typedef struct packed {
		logic [31:0] value;
		memKindE memKind;
		logic illegal;
	} execS;

	typedef struct packed {
		logic [31:0] value;
		logic [3:0] byteEnable;
		logic addrError;
		logic illegal;
	} resultS;

endpackage

`default_nettype wire

// ==== src/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, // R-format, decoded by func
		OP_ADDIU = 6'h09,
		OP_SLTI = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ANDI = 6'h0c,
		OP_ORI = 6'h0d,
		OP_XORI = 6'h0e,
		OP_LUI = 6'h0f,
		OP_LB = 6'h20,
		OP_LH = 6'h21,
		OP_LWL = 6'h22,
		OP_LW = 6'h23,
		OP_LBU = 6'h24,
		OP_LHU = 6'h25,
		OP_LWR = 6'h26,
		OP_SB = 6'h28,
		OP_SH = 6'h29,
		OP_SW = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_SRL = 6'h02,
		FN_SRA = 6'h03,
		FN_SLLV = 6'h04, // Bit 2 marks the variable shifts
		FN_SRLV = 6'h06,
		FN_SRAV = 6'h07,
		FN_MFHI = 6'h10,
		FN_MTHI = 6'h11,
		FN_MFLO = 6'h12,
		FN_MTLO = 6'h13,
		FN_MULT = 6'h18,
		FN_MULTU = 6'h19,
		FN_DIV = 6'h1a,
		FN_DIVU = 6'h1b,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND = 6'h24,
		FN_OR = 6'h25,
		FN_XOR = 6'h26,
		FN_SLT = 6'h2a,
		FN_SLTU = 6'h2b
	} funcE;

	typedef struct packed {
		opcodeE opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funcE func;
	} rTypeS;

	typedef struct packed {
		opcodeE opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iTypeS;

	typedef union packed {
		rTypeS r;
		iTypeS i;
	} instrU;

endpackage

`default_nettype wire
